// File: dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BLOCK_W  = 128;            // 16 bytes per block
    localparam int OFFSET_W = 4;
    localparam int INDEX_W  = 8;              // address bits 11:4
    localparam int TAG_W    = 20;             // address bits 31:12

    // backing memory
    localparam int MEM_BLOCKS  = 1024;        // 16 KB, address bits 13:4
    localparam int MEM_INDEX_W = $clog2(MEM_BLOCKS);
    localparam int MEM_LATENCY = 4;
    localparam int LAT_CNT_W   = $clog2(MEM_LATENCY + 1);

    typedef enum logic [3:0] {
        OP_LB  = 4'd0,
        OP_LH  = 4'd1,
        OP_LW  = 4'd2,
        OP_LBU = 4'd3,
        OP_LHU = 4'd4,
        OP_SB  = 4'd5,
        OP_SH  = 4'd6,
        OP_SW  = 4'd7
    } mem_op_t;

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WRITEBACK = 3'd2,
        ST_REFILL    = 3'd3,
        ST_RESPOND   = 3'd4
    } ctrl_state_t;

endpackage

// File: dcache_array.sv
`timescale 1ns/1ns

module dcache_array
    import dcache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic [INDEX_W-1:0] index_i,
    input  logic               we_i,
    input  logic [TAG_W-1:0]   wtag_i,
    input  logic [BLOCK_W-1:0] wdata_i,
    input  logic               wdirty_i,
    output logic               rvalid_o,
    output logic [TAG_W-1:0]   rtag_o,
    output logic               rdirty_o,
    output logic [BLOCK_W-1:0] rdata_o
);

    logic [TAG_W-1:0]     tag_mem  [2**INDEX_W];
    logic [BLOCK_W-1:0]   data_mem [2**INDEX_W];
    logic [2**INDEX_W-1:0] valid_q;
    logic [2**INDEX_W-1:0] dirty_q;

    // status bits per set
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q  <= '0;
            dirty_q  <= '0;
            rvalid_o <= 1'b0;
            rdirty_o <= 1'b0;
        end else begin
            rvalid_o <= valid_q[index_i];   // read returns the old entry on a same-cycle write
            rdirty_o <= dirty_q[index_i];
            if (we_i) begin
                valid_q[index_i] <= 1'b1;
                dirty_q[index_i] <= wdirty_i;
            end
        end
    end

    // tag and data storage
    always_ff @(posedge clk_i) begin
        rtag_o  <= tag_mem[index_i];
        rdata_o <= data_mem[index_i];
        if (we_i) begin
            tag_mem[index_i]  <= wtag_i;
            data_mem[index_i] <= wdata_i;
        end
    end

endmodule

// File: lsu_align.sv
`timescale 1ns/1ns

module lsu_align
    import dcache_pkg::*;
(
    input  mem_op_t             op_i,
    input  logic [OFFSET_W-1:0] offset_i,
    input  logic [BLOCK_W-1:0]  block_i,
    input  logic [DATA_W-1:0]   wdata_i,
    output logic [DATA_W-1:0]   load_data_o,
    output logic [BLOCK_W-1:0]  merged_block_o
);

    logic [OFFSET_W+2:0] shamt;
    logic [BLOCK_W-1:0]  shifted;
    logic [DATA_W-1:0]   wmask;
    logic [BLOCK_W-1:0]  block_mask;
    logic [BLOCK_W-1:0]  block_wdata;

    assign shamt   = {offset_i, 3'b000};    // byte offset to bit offset
    assign shifted = block_i >> shamt;

    always_comb begin
        case (op_i)
            OP_LB:   load_data_o = {{24{shifted[7]}}, shifted[7:0]};
            OP_LH:   load_data_o = {{16{shifted[15]}}, shifted[15:0]};
            OP_LW:   load_data_o = shifted[31:0];
            OP_LBU:  load_data_o = {24'b0, shifted[7:0]};
            OP_LHU:  load_data_o = {16'b0, shifted[15:0]};
            default: load_data_o = '0;       // stores return zero
        endcase
    end

    always_comb begin
        case (op_i)
            OP_SB:   wmask = 32'h0000_00ff;
            OP_SH:   wmask = 32'h0000_ffff;
            OP_SW:   wmask = 32'hffff_ffff;
            default: wmask = 32'h0000_0000;  // loads leave the block untouched
        endcase
    end

    assign block_mask  = {{(BLOCK_W-DATA_W){1'b0}}, wmask} << shamt;
    assign block_wdata = {{(BLOCK_W-DATA_W){1'b0}}, wdata_i} << shamt;

    assign merged_block_o = (block_i & ~block_mask) | (block_wdata & block_mask);

endmodule

// File: dcache_ctrl.sv
`timescale 1ns/1ns

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_i,
    // core side
    input  logic                req_valid_i,
    output logic                req_ready_o,
    input  mem_op_t             req_op_i,
    input  logic [ADDR_W-1:0]   req_addr_i,
    input  logic [DATA_W-1:0]   req_wdata_i,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,
    output logic [DATA_W-1:0]   rsp_rdata_o,
    // memory side
    output logic                mem_req_valid_o,
    output logic                mem_req_we_o,
    output logic [ADDR_W-1:0]   mem_req_addr_o,
    output logic [BLOCK_W-1:0]  mem_req_wdata_o,
    input  logic                mem_req_ready_i,
    input  logic                mem_rsp_valid_i,
    input  logic [BLOCK_W-1:0]  mem_rsp_rdata_i,
    // array
    output logic [INDEX_W-1:0]  arr_index_o,
    output logic                arr_we_o,
    output logic [TAG_W-1:0]    arr_wtag_o,
    output logic [BLOCK_W-1:0]  arr_wdata_o,
    output logic                arr_wdirty_o,
    input  logic                arr_rvalid_i,
    input  logic [TAG_W-1:0]    arr_rtag_i,
    input  logic                arr_rdirty_i,
    input  logic [BLOCK_W-1:0]  arr_rdata_i,
    // alignment unit
    output mem_op_t             al_op_o,
    output logic [OFFSET_W-1:0] al_offset_o,
    output logic [BLOCK_W-1:0]  al_block_o,
    output logic [DATA_W-1:0]   al_wdata_o,
    input  logic [DATA_W-1:0]   al_load_data_i,
    input  logic [BLOCK_W-1:0]  al_merged_i
);

    ctrl_state_t         state_q, state_d;
    logic                rd_sent_q;             // refill read already accepted
    mem_op_t             op_q;
    logic [ADDR_W-1:0]   addr_q;
    logic [DATA_W-1:0]   wdata_q;
    logic [DATA_W-1:0]   rdata_q;
    logic                is_store;
    logic                hit;

    assign is_store = (op_q == OP_SB) || (op_q == OP_SH) || (op_q == OP_SW);
    assign hit      = arr_rvalid_i && (arr_rtag_i == addr_q[ADDR_W-1 -: TAG_W]);

    assign req_ready_o = (state_q == ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESPOND);
    assign rsp_rdata_o = rdata_q;

    // index the array straight from the request so lookup data is ready next cycle
    assign arr_index_o  = (state_q == ST_IDLE) ? req_addr_i[OFFSET_W +: INDEX_W]
                                               : addr_q[OFFSET_W +: INDEX_W];
    assign arr_wtag_o   = addr_q[ADDR_W-1 -: TAG_W];
    assign arr_wdata_o  = al_merged_i;
    assign arr_wdirty_o = is_store;

    assign al_op_o     = op_q;
    assign al_offset_o = addr_q[OFFSET_W-1:0];
    assign al_wdata_o  = wdata_q;
    assign al_block_o  = (state_q == ST_REFILL) ? mem_rsp_rdata_i : arr_rdata_i;

    assign mem_req_wdata_o = arr_rdata_i;      // victim block

    always_comb begin
        state_d         = state_q;
        mem_req_valid_o = 1'b0;
        mem_req_we_o    = 1'b0;
        mem_req_addr_o  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        arr_we_o        = 1'b0;
        case (state_q)
            ST_IDLE: begin
                if (req_valid_i) begin
                    state_d = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    arr_we_o = is_store;
                    state_d  = ST_RESPOND;
                end else if (arr_rvalid_i && arr_rdirty_i) begin
                    state_d = ST_WRITEBACK;
                end else begin
                    state_d = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                mem_req_valid_o = 1'b1;
                mem_req_we_o    = 1'b1;
                mem_req_addr_o  = {arr_rtag_i, addr_q[OFFSET_W +: INDEX_W], {OFFSET_W{1'b0}}};
                if (mem_req_ready_i) begin
                    state_d = ST_REFILL;
                end
            end
            ST_REFILL: begin
                mem_req_valid_o = !rd_sent_q;
                if (mem_rsp_valid_i) begin
                    arr_we_o = 1'b1;            // stores land dirty, loads clean
                    state_d  = ST_RESPOND;
                end
            end
            ST_RESPOND: begin
                if (rsp_ready_i) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q   <= ST_IDLE;
            rd_sent_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_d != ST_REFILL) begin
                rd_sent_q <= 1'b0;
            end else if (state_q == ST_REFILL && mem_req_valid_o && mem_req_ready_i) begin
                rd_sent_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            op_q    <= req_op_i;
            addr_q  <= req_addr_i;
            wdata_q <= req_wdata_i;
        end
        if ((state_q == ST_LOOKUP && hit) || (state_q == ST_REFILL && mem_rsp_valid_i)) begin
            rdata_q <= is_store ? '0 : al_load_data_i;
        end
    end

endmodule

// File: block_memory.sv
`timescale 1ns/1ns

module block_memory
    import dcache_pkg::*;
(
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               req_valid_i,
    input  logic               req_we_i,
    input  logic [ADDR_W-1:0]  req_addr_i,
    input  logic [BLOCK_W-1:0] req_wdata_i,
    output logic               req_ready_o,
    output logic               rsp_valid_o,
    output logic [BLOCK_W-1:0] rsp_rdata_o
);

    logic [BLOCK_W-1:0]     mem [MEM_BLOCKS];
    logic [MEM_BLOCKS-1:0]  written_q;          // unwritten blocks read as zero
    logic [MEM_INDEX_W-1:0] req_idx;
    logic [MEM_INDEX_W-1:0] rd_idx_q;
    logic [LAT_CNT_W-1:0]   cnt_q;
    logic                   pending_q;

    assign req_idx     = req_addr_i[OFFSET_W +: MEM_INDEX_W];
    assign req_ready_o = !pending_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            written_q   <= '0;
            pending_q   <= 1'b0;
            cnt_q       <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= 1'b0;
            if (req_valid_i && req_ready_o) begin
                if (req_we_i) begin
                    written_q[req_idx] <= 1'b1;
                end else begin
                    pending_q <= 1'b1;
                    cnt_q     <= LAT_CNT_W'(MEM_LATENCY - 1);
                end
            end else if (pending_q) begin
                if (cnt_q == '0) begin
                    pending_q   <= 1'b0;
                    rsp_valid_o <= 1'b1;  // one-cycle strobe
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_ready_o) begin
            if (req_we_i) begin
                mem[req_idx] <= req_wdata_i;
            end else begin
                rd_idx_q <= req_idx;
            end
        end
        if (pending_q && cnt_q == '0) begin
            rsp_rdata_o <= written_q[rd_idx_q] ? mem[rd_idx_q] : '0;
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ns

module dcache_top
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    output logic              req_ready_o,
    input  mem_op_t           req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    output logic              rsp_valid_o,
    input  logic              rsp_ready_i,
    output logic [DATA_W-1:0] rsp_rdata_o
);

    logic                mem_req_valid;
    logic                mem_req_we;
    logic [ADDR_W-1:0]   mem_req_addr;
    logic [BLOCK_W-1:0]  mem_req_wdata;
    logic                mem_req_ready;
    logic                mem_rsp_valid;
    logic [BLOCK_W-1:0]  mem_rsp_rdata;

    logic [INDEX_W-1:0]  arr_index;
    logic                arr_we;
    logic [TAG_W-1:0]    arr_wtag;
    logic [BLOCK_W-1:0]  arr_wdata;
    logic                arr_wdirty;
    logic                arr_rvalid;
    logic [TAG_W-1:0]    arr_rtag;
    logic                arr_rdirty;
    logic [BLOCK_W-1:0]  arr_rdata;

    mem_op_t             al_op;
    logic [OFFSET_W-1:0] al_offset;
    logic [BLOCK_W-1:0]  al_block;
    logic [DATA_W-1:0]   al_wdata;
    logic [DATA_W-1:0]   load_data;
    logic [BLOCK_W-1:0]  merged_block;

    dcache_ctrl ctrl_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_ready_o     (req_ready_o),
        .req_op_i        (req_op_i),
        .req_addr_i      (req_addr_i),
        .req_wdata_i     (req_wdata_i),
        .rsp_valid_o     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_rdata_o     (rsp_rdata_o),
        .mem_req_valid_o (mem_req_valid),
        .mem_req_we_o    (mem_req_we),
        .mem_req_addr_o  (mem_req_addr),
        .mem_req_wdata_o (mem_req_wdata),
        .mem_req_ready_i (mem_req_ready),
        .mem_rsp_valid_i (mem_rsp_valid),
        .mem_rsp_rdata_i (mem_rsp_rdata),
        .arr_index_o     (arr_index),
        .arr_we_o        (arr_we),
        .arr_wtag_o      (arr_wtag),
        .arr_wdata_o     (arr_wdata),
        .arr_wdirty_o    (arr_wdirty),
        .arr_rvalid_i    (arr_rvalid),
        .arr_rtag_i      (arr_rtag),
        .arr_rdirty_i    (arr_rdirty),
        .arr_rdata_i     (arr_rdata),
        .al_op_o         (al_op),
        .al_offset_o     (al_offset),
        .al_block_o      (al_block),
        .al_wdata_o      (al_wdata),
        .al_load_data_i  (load_data),
        .al_merged_i     (merged_block)
    );

    dcache_array array_i (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .index_i  (arr_index),
        .we_i     (arr_we),
        .wtag_i   (arr_wtag),
        .wdata_i  (arr_wdata),
        .wdirty_i (arr_wdirty),
        .rvalid_o (arr_rvalid),
        .rtag_o   (arr_rtag),
        .rdirty_o (arr_rdirty),
        .rdata_o  (arr_rdata)
    );

    lsu_align align_i (
        .op_i           (al_op),
        .offset_i       (al_offset),
        .block_i        (al_block),
        .wdata_i        (al_wdata),
        .load_data_o    (load_data),
        .merged_block_o (merged_block)
    );

    block_memory mem_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (mem_req_valid),
        .req_we_i    (mem_req_we),
        .req_addr_i  (mem_req_addr),
        .req_wdata_i (mem_req_wdata),
        .req_ready_o (mem_req_ready),
        .rsp_valid_o (mem_rsp_valid),
        .rsp_rdata_o (mem_rsp_rdata)
    );

endmodule

// File: dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  logic              req_ready_i,
    input  logic              rsp_valid_i,
    input  logic              rsp_ready_i,
    input  logic [DATA_W-1:0] rsp_rdata_i,
    input  logic              mem_req_valid_i,
    input  logic              mem_req_ready_i,
    input  logic [ADDR_W-1:0] mem_req_addr_i
);

    int   fail_count = 0;
    logic busy_q;                               // request accepted, response not yet taken

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q <= 1'b0;
        end else if (req_valid_i && req_ready_i) begin
            busy_q <= 1'b1;
        end else if (rsp_valid_i && rsp_ready_i) begin
            busy_q <= 1'b0;
        end
    end

    rsp_stable_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_rdata_i))
        else begin
            $error("response dropped or changed before rsp_ready_i");
            fail_count++;
        end

    // one transaction at a time on the core side
    no_accept_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        (busy_q || rsp_valid_i) |-> busy_q && !req_ready_i)
        else begin
            $error("req_ready_o high or response raised without an outstanding request");
            fail_count++;
        end

    mem_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_addr_i))
        else begin
            $error("memory request withdrawn or changed before acceptance");
            fail_count++;
        end

endmodule

// File: dcache_monitor.sv
`timescale 1ns/1ns

module dcache_monitor
    import dcache_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              req_valid_i,
    input  logic              req_ready_i,
    input  mem_op_t           req_op_i,
    input  logic [ADDR_W-1:0] req_addr_i,
    input  logic [DATA_W-1:0] req_wdata_i,
    input  logic              rsp_valid_i,
    input  logic              rsp_ready_i,
    input  logic [DATA_W-1:0] rsp_rdata_i,
    output int                err_count_o,
    output int                rsp_count_o
);

    logic [7:0]        shadow [MEM_BLOCKS*BLOCK_W/8];   // byte image of the 16 KB memory
    logic [DATA_W-1:0] exp_q [$];
    logic [DATA_W-1:0] exp_val;

    initial begin
        for (int i = 0; i < MEM_BLOCKS*BLOCK_W/8; i++) begin
            shadow[i] = 8'h00;
        end
    end

    // expected load value, or the shadow update for a store
    function automatic logic [DATA_W-1:0] ref_access(input mem_op_t op,
                                                     input logic [ADDR_W-1:0] addr,
                                                     input logic [DATA_W-1:0] wdata);
        logic [13:0]       a0;
        logic [13:0]       a1;
        logic [13:0]       a2;
        logic [13:0]       a3;
        logic [DATA_W-1:0] result;
        a0     = addr[13:0];                  // memory ignores the upper bits
        a1     = a0 + 14'd1;
        a2     = a0 + 14'd2;
        a3     = a0 + 14'd3;
        result = '0;
        case (op)
            OP_LB:  result = {{24{shadow[a0][7]}}, shadow[a0]};
            OP_LBU: result = {24'h0, shadow[a0]};
            OP_LH:  result = {{16{shadow[a1][7]}}, shadow[a1], shadow[a0]};
            OP_LHU: result = {16'h0, shadow[a1], shadow[a0]};
            OP_LW:  result = {shadow[a3], shadow[a2], shadow[a1], shadow[a0]};
            OP_SB:  shadow[a0] = wdata[7:0];
            OP_SH: begin
                shadow[a0] = wdata[7:0];
                shadow[a1] = wdata[15:8];
            end
            OP_SW: begin
                shadow[a0] = wdata[7:0];
                shadow[a1] = wdata[15:8];
                shadow[a2] = wdata[23:16];
                shadow[a3] = wdata[31:24];
            end
            default: result = '0;
        endcase
        return result;                        // stores answer with zero
    endfunction

    always @(posedge clk_i) begin
        if (!rst_i) begin
            exp_q.delete();
            err_count_o = 0;
            rsp_count_o = 0;
        end else begin
            if (rsp_valid_i && rsp_ready_i) begin
                if (exp_q.size() == 0) begin
                    $display("ERROR: response at %0t with no request outstanding", $time);
                    err_count_o++;
                end else begin
                    exp_val = exp_q.pop_front();
                    rsp_count_o++;
                    if (rsp_rdata_i !== exp_val) begin
                        $display("CHECK FAILED rsp_rdata_o got %h expected %h at %0t",
                                 rsp_rdata_i, exp_val, $time);
                        err_count_o++;
                    end
                end
            end
            if (req_valid_i && req_ready_i) begin
                exp_q.push_back(ref_access(req_op_i, req_addr_i, req_wdata_i));
            end
        end
    end

endmodule

// File: tb_dcache.sv
`timescale 1ns/1ns

module tb_dcache
    import dcache_pkg::*;
();

    localparam int TIMEOUT = 100;

    logic              clk_i;
    logic              rst_i;
    logic              req_valid_i;
    logic              req_ready_o;
    mem_op_t           req_op_i;
    logic [ADDR_W-1:0] req_addr_i;
    logic [DATA_W-1:0] req_wdata_i;
    logic              rsp_valid_o;
    logic              rsp_ready_i;
    logic [DATA_W-1:0] rsp_rdata_o;

    int                tb_errors;
    int                mon_errors;
    int                rsp_checked;
    int                pass_cnt;
    int                fail_cnt;
    int                err_mark;
    int                lat;
    logic [31:0]       rng_q;
    logic [31:0]       r;
    logic [DATA_W-1:0] held;
    mem_op_t           op;
    logic [ADDR_W-1:0] addr;

    dcache_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_o (req_ready_o),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o)
    );

    dcache_monitor monitor_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_valid_i (req_valid_i),
        .req_ready_i (req_ready_o),
        .req_op_i    (req_op_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .rsp_valid_i (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_i (rsp_rdata_o),
        .err_count_o (mon_errors),
        .rsp_count_o (rsp_checked)
    );

    bind dcache_top dcache_checker checker_i (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .req_valid_i     (req_valid_i),
        .req_ready_i     (req_ready_o),
        .rsp_valid_i     (rsp_valid_o),
        .rsp_ready_i     (rsp_ready_i),
        .rsp_rdata_i     (rsp_rdata_o),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_ready_i (mem_req_ready),
        .mem_req_addr_i  (mem_req_addr)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_q = xorshift32(rng_q);
        return rng_q;
    endfunction

    function automatic int error_total();
        return tb_errors + mon_errors + dut_i.checker_i.fail_count;
    endfunction

    // called on a falling edge, returns on the falling edge after the handshake
    task automatic send_req(input mem_op_t op_a, input logic [ADDR_W-1:0] addr_a,
                            input logic [DATA_W-1:0] data_a);
        int waited;
        req_valid_i = 1'b1;
        req_op_i    = op_a;
        req_addr_i  = addr_a;
        req_wdata_i = data_a;
        waited      = 0;
        while (!req_ready_o && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
        end
        if (!req_ready_o) begin
            $display("ERROR: request not accepted within %0d cycles", TIMEOUT);
            tb_errors++;
        end
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic take_rsp(input bit random_ready, output int latency);
        int          waited;
        logic [31:0] coin;
        waited = 0;
        coin   = random_ready ? next_rand() : 32'hffff_ffff;
        rsp_ready_i = coin[3];
        while (!(rsp_valid_o && rsp_ready_i) && waited < TIMEOUT) begin
            @(negedge clk_i);
            waited++;
            if (random_ready) begin
                coin = next_rand();
                rsp_ready_i = coin[3];
            end
        end
        if (!(rsp_valid_o && rsp_ready_i)) begin
            $display("ERROR: no response taken within %0d cycles", TIMEOUT);
            tb_errors++;
        end
        latency = waited + 1;                 // cycles from request handshake to rsp_valid_o
        @(negedge clk_i);
    endtask

    task automatic access(input mem_op_t op_a, input logic [ADDR_W-1:0] addr_a,
                          input logic [DATA_W-1:0] data_a, input bit hit_expected);
        int cycles;
        send_req(op_a, addr_a, data_a);
        take_rsp(1'b0, cycles);
        if (hit_expected && cycles != 2) begin
            $display("CHECK FAILED rsp_valid_o hit latency got %h expected %h", cycles, 2);
            tb_errors++;
        end
    endtask

    task automatic close_test(input string name, input int mark);
        int errs;
        errs = error_total() - mark;
        if (errs == 0) begin
            pass_cnt++;
            $display("test %-28s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-28s FAILED with %0d error(s)", name, errs);
        end
    endtask

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b0;
        req_valid_i = 1'b0;
        req_op_i    = OP_LW;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b1;
        rng_q       = 32'hb41b_bcd5;
        tb_errors   = 0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b1;

        err_mark = error_total();
        if (req_ready_o !== 1'b1) begin
            $display("CHECK FAILED req_ready_o got %h expected %h", req_ready_o, 1'b1);
            tb_errors++;
        end
        if (rsp_valid_o !== 1'b0) begin
            $display("CHECK FAILED rsp_valid_o got %h expected %h", rsp_valid_o, 1'b0);
            tb_errors++;
        end
        close_test("reset state", err_mark);

        err_mark = error_total();
        access(OP_LW, 32'h0000_0100, '0, 1'b0);         // cold miss reads zero
        access(OP_SW, 32'h0000_0100, next_rand(), 1'b1);
        access(OP_SW, 32'h0000_0104, next_rand(), 1'b1);
        access(OP_SH, 32'h0000_0108, next_rand(), 1'b1);
        access(OP_SH, 32'h0000_010a, next_rand(), 1'b1);
        for (int i = 12; i < 16; i++) begin
            access(OP_SB, 32'h0000_0100 + i, next_rand(), 1'b1);
        end
        for (int i = 0; i < 16; i++) begin
            access(OP_LB, 32'h0000_0100 + i, '0, 1'b1);
            access(OP_LBU, 32'h0000_0100 + i, '0, 1'b1);
            if (i % 2 == 0) begin
                access(OP_LH, 32'h0000_0100 + i, '0, 1'b1);
                access(OP_LHU, 32'h0000_0100 + i, '0, 1'b1);
            end
            if (i % 4 == 0) begin
                access(OP_LW, 32'h0000_0100 + i, '0, 1'b1);
            end
        end
        close_test("hit path and alignment", err_mark);

        err_mark = error_total();
        access(OP_SW, 32'h0000_0240, 32'hc0de_5a17, 1'b0);
        access(OP_SW, 32'h0000_1240, 32'h0bad_cafe, 1'b0);  // same set, dirty victim
        access(OP_LW, 32'h0000_0240, '0, 1'b0);
        access(OP_LH, 32'h0000_1242, '0, 1'b0);
        close_test("eviction and writeback", err_mark);

        err_mark = error_total();
        rsp_ready_i = 1'b0;
        send_req(OP_LW, 32'h0000_0104, '0);
        lat = 0;
        while (!rsp_valid_o && lat < TIMEOUT) begin
            @(negedge clk_i);
            lat++;
        end
        if (!rsp_valid_o) begin
            $display("ERROR: no response raised while rsp_ready_i was held low");
            tb_errors++;
        end
        held        = rsp_rdata_o;
        req_valid_i = 1'b1;                   // next request waits behind the response
        req_op_i    = OP_LBU;
        req_addr_i  = 32'h0000_0107;
        req_wdata_i = '0;
        repeat (5) begin
            @(negedge clk_i);
            if (rsp_rdata_o !== held) begin
                $display("CHECK FAILED rsp_rdata_o got %h expected %h", rsp_rdata_o, held);
                tb_errors++;
            end
            if (req_ready_o !== 1'b0) begin
                $display("CHECK FAILED req_ready_o got %h expected %h", req_ready_o, 1'b0);
                tb_errors++;
            end
        end
        rsp_ready_i = 1'b1;
        send_req(OP_LBU, 32'h0000_0107, '0);
        take_rsp(1'b0, lat);
        close_test("response back-pressure", err_mark);

        err_mark = error_total();
        for (int n = 0; n < 300; n++) begin
            r    = next_rand();
            op   = mem_op_t'({1'b0, r[2:0]});
            addr = next_rand() & 32'h0000_303f;       // 4 tags over 4 sets
            if (op == OP_LH || op == OP_LHU || op == OP_SH) begin
                addr[0] = 1'b0;
            end else if (op == OP_LW || op == OP_SW) begin
                addr[1:0] = 2'b00;
            end
            send_req(op, addr, next_rand());
            take_rsp(1'b1, lat);
        end
        rsp_ready_i = 1'b1;
        close_test("random traffic", err_mark);

        $display("summary: %0d tests ok, %0d tests failed, %0d responses compared, %0d errors",
                 pass_cnt, fail_cnt, rsp_checked, error_total());
        if (fail_cnt == 0 && error_total() == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sim.f
dcache_pkg.sv
dcache_array.sv
lsu_align.sv
dcache_ctrl.sv
block_memory.sv
dcache_top.sv
dcache_checker.sv
dcache_monitor.sv
tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
